// ==== tests/mul_stimulus.txt ====
// columns: a (32 bit hex), b (32 bit hex), expected product a*b (64 bit hex)
// corners first, then alternating patterns and mixed values
00000000 00000000 0000000000000000
00000000 ffffffff 0000000000000000
ffffffff 00000000 0000000000000000
00000001 00000001 0000000000000001
ffffffff ffffffff fffffffe00000001
ffffffff 00000001 00000000ffffffff
00000001 ffffffff 00000000ffffffff
80000000 80000000 4000000000000000
80000000 00000002 0000000100000000
00010000 00010000 0000000100000000
00000400 00100000 0000000040000000
00000002 40000000 0000000080000000
ffffffff 80000000 7fffffff80000000
7fffffff 7fffffff 3fffffff00000001
55555555 55555555 1c71c71c38e38e39
aaaaaaaa 55555555 38e38e3871c71c72
aaaaaaaa aaaaaaaa 71c71c70e38e38e4
0000ffff 0000ffff 00000000fffe0001
00010001 00010001 0000000100020001
0f0f0f0f 00000011 00000000ffffffff
f0f0f0f0 00000010 0000000f0f0f0f00
12345678 00000010 0000000123456780
deadbeef 00000100 000000deadbeef00
0000ffff 12345678 000012344443a988
9e3779b9 00000003 00000001daa66d2b
89abcdef 00000002 0000000113579bde
0000abcd 00001234 000000000c374fa4
00000003 fffffffd 00000002fffffff7
0000000a 0000000b 000000000000006e
000003e8 000003e8 00000000000f4240

// ==== filelist.f ====
source/mul_pkg.sv
source/carry_save_if.sv
source/partial_products.sv
source/wallace_tree.sv
source/carry_prop_adder.sv
source/result_queue.sv
source/mul_unit.sv
tests/tb_clock_gen.sv
tests/mul_unit_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = mul_unit_tb
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/mul_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_unit_tb;
	import mul_pkg::*;

	localparam int STIM_RECORDS = 30;
	localparam int TOTAL_OPS    = 3 * STIM_RECORDS;
	localparam int WAIT_LIMIT   = 4000; // cycles allowed for any single wait.

	typedef struct {
		mul_tag_t     tag;
		mul_product_t file_prod;
		mul_product_t calc_prod;
	} expect_t;

	logic         clk;
	logic         arst_n;
	logic         in_valid;
	mul_operand_t in_a;
	mul_operand_t in_b;
	mul_tag_t     in_tag;
	logic         in_credit;
	logic         out_credit;
	logic         out_valid;
	mul_product_t out_product;
	mul_tag_t     out_tag;

	mul_product_t stim_mem [3 * STIM_RECORDS]; // a, b, product per record.
	expect_t      scoreboard [$];
	mul_tag_t     next_tag     = '0;
	int           prod_credits = RESULT_DEPTH; // input credits held by the producer.
	int           issued       = 0;
	int           received     = 0;
	int           granted      = 0;
	int           returned     = 0;
	int           gap_left     = 0;

	tb_clock_gen #(
		.PERIOD_NS    (10.0),
		.RESET_CYCLES (5)
	) i_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mul_unit i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_a        (in_a),
		.in_b        (in_b),
		.in_tag      (in_tag),
		.in_credit   (in_credit),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_product (out_product),
		.out_tag     (out_tag)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_product(input string name, input mul_product_t got,
		input mul_product_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_tag(input string name, input mul_tag_t got, input mul_tag_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic issue_op(input int rec);
		expect_t e;
		in_valid    = 1'b1;
		in_a        = stim_mem[3*rec][31:0];
		in_b        = stim_mem[3*rec+1][31:0];
		in_tag      = next_tag;
		e.tag       = next_tag;
		e.file_prod = stim_mem[3*rec+2];
		e.calc_prod = mul_product_t'(in_a) * mul_product_t'(in_b);
		scoreboard.push_back(e);
		next_tag     = next_tag + 1'b1;
		prod_credits = prod_credits - 1;
		issued       = issued + 1;
	endtask

	// bursty grants with occasional long silences.
	function automatic logic random_grant();
		if (granted - received >= RESULT_DEPTH) begin
			return 1'b0; // the consumer has room for RESULT_DEPTH results at most.
		end
		if (gap_left > 0) begin
			gap_left = gap_left - 1;
			return 1'b0;
		end
		if ($urandom_range(15) == 0) begin
			gap_left = $urandom_range(40, 12);
			return 1'b0;
		end
		return $urandom_range(2) != 0;
	endfunction

	always @(posedge clk) begin
		expect_t head;
		if (arst_n) begin
			if (out_valid) begin
				if (granted == received) begin
					abort_run("out_valid was raised without an output credit");
				end
				if (scoreboard.size() == 0) begin
					abort_run("out_valid was raised with no operation outstanding");
				end
				head = scoreboard.pop_front();
				check_tag("out_tag", out_tag, head.tag);
				check_product("out_product", out_product, head.file_prod);
				check_product("out_product (a*b)", out_product, head.calc_prod);
				received = received + 1;
			end
			if (out_credit) begin
				granted = granted + 1;
			end
			if (in_credit) begin
				returned     = returned + 1;
				prod_credits = prod_credits + 1;
			end
		end
	end

	initial begin
		int    accepted;
		int    latency;
		int    cycles;
		string problem;
		void'($urandom(32'h8771d8d5));
		in_valid   = 1'b0;
		in_a       = '0;
		in_b       = '0;
		in_tag     = '0;
		out_credit = 1'b0;
		$readmemh("tests/mul_stimulus.txt", stim_mem);

		cycles = 0;
		while (arst_n !== 1'b1) begin
			if (cycles == 100) begin
				abort_run("reset was never released");
			end
			next_cycle();
			cycles++;
		end

		// idle after reset, no credits granted.
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
				abort_run("out_valid or in_credit was active after reset without credits");
			end
		end

		// one banked credit, then a single operation.
		out_credit = 1'b1;
		next_cycle();
		out_credit = 1'b0;
		issue_op(0);
		next_cycle();
		in_valid = 1'b0;
		latency  = 0;
		while (out_valid !== 1'b1) begin
			if (latency == 20) begin
				abort_run("timeout waiting for the single result");
			end
			next_cycle();
			latency++;
		end
		if (latency != 3) begin
			abort_run($sformatf("single result came %0d edges after issue, not 3", latency));
		end

		// output credits withheld.
		accepted = 0;
		for (int i = 0; i < 40; i++) begin
			next_cycle();
			if (in_credit !== 1'b0) begin
				abort_run("in_credit pulsed while output credits were withheld");
			end
			if (prod_credits > 0) begin
				issue_op(1 + accepted);
				accepted++;
			end else begin
				in_valid = 1'b0;
			end
		end
		if (accepted != RESULT_DEPTH) begin
			abort_run($sformatf("%0d operations accepted under back-pressure", accepted));
		end

		cycles = 0;
		while (issued < TOTAL_OPS) begin
			if (cycles == WAIT_LIMIT) begin
				abort_run("timeout while issuing operations");
			end
			out_credit = random_grant();
			if (prod_credits > 0 && $urandom_range(3) != 0) begin
				issue_op(issued % STIM_RECORDS);
			end else begin
				in_valid = 1'b0;
			end
			next_cycle();
			cycles++;
		end
		in_valid = 1'b0;

		cycles = 0;
		while (received < issued) begin
			if (cycles == WAIT_LIMIT) begin
				abort_run("timeout waiting for outstanding results");
			end
			out_credit = random_grant();
			next_cycle();
			cycles++;
		end
		out_credit = 1'b0;
		next_cycle();
		next_cycle();

		problem = "";
		if (returned != received) begin
			problem = $sformatf("%0d input credits came back for %0d results", returned, received);
		end else if (prod_credits != RESULT_DEPTH) begin
			problem = $sformatf("producer ended with %0d input credits", prod_credits);
		end else if (scoreboard.size() != 0) begin
			problem = "operations were left without a result";
		end
		if (problem == "") begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run(problem);
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS    = 10.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0);
			clk = ~clk;
		end
	end

	// reset leaves at a falling edge, away from the stimulus updates.
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/mul_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  mul_pkg::mul_operand_t in_a,
	input  mul_pkg::mul_operand_t in_b,
	input  mul_pkg::mul_tag_t     in_tag,
	output logic                  in_credit,
	input  logic                  out_credit,
	output logic                  out_valid,
	output mul_pkg::mul_product_t out_product,
	output mul_pkg::mul_tag_t     out_tag
);
	import mul_pkg::*;

	logic         pp_valid;
	mul_rows_t    pp_rows;
	mul_tag_t     pp_tag;
	logic         add_push;
	mul_product_t add_product;
	mul_tag_t     add_tag;

	carry_save_if cs_bus ();

	partial_products i_partial_products (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.a        (in_a),
		.b        (in_b),
		.tag      (in_tag),
		.pp_valid (pp_valid),
		.pp_rows  (pp_rows),
		.pp_tag   (pp_tag)
	);

	wallace_tree i_wallace_tree (
		.clk      (clk),
		.arst_n   (arst_n),
		.pp_valid (pp_valid),
		.pp_rows  (pp_rows),
		.pp_tag   (pp_tag),
		.cs       (cs_bus.source)
	);

	carry_prop_adder i_carry_prop_adder (
		.clk     (clk),
		.arst_n  (arst_n),
		.cs      (cs_bus.sink),
		.push    (add_push),
		.product (add_product),
		.tag     (add_tag)
	);

	result_queue #(
		.DEPTH (RESULT_DEPTH)
	) i_result_queue (
		.clk         (clk),
		.arst_n      (arst_n),
		.push        (add_push),
		.product     (add_product),
		.tag         (add_tag),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_product (out_product),
		.out_tag     (out_tag),
		.in_credit   (in_credit)
	);

endmodule

`default_nettype wire

// ==== source/result_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_queue #(
	parameter int DEPTH = mul_pkg::RESULT_DEPTH
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  push,
	input  mul_pkg::mul_product_t product,
	input  mul_pkg::mul_tag_t     tag,
	input  logic                  out_credit,
	output logic                  out_valid,
	output mul_pkg::mul_product_t out_product,
	output mul_pkg::mul_tag_t     out_tag,
	output logic                  in_credit
);
	import mul_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	mul_product_t     prod_mem [DEPTH];
	mul_tag_t         tag_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	mul_count_t       fill_cnt;
	mul_count_t       credit_cnt; // granted and not yet spent.
	logic             empty;
	logic             send;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty       = (fill_cnt == '0);
	// an empty buffer hands the incoming result straight through.
	assign send        = (!empty || push) && (credit_cnt != '0);
	assign out_valid   = send;
	assign out_product = empty ? product : prod_mem[rd_ptr];
	assign out_tag     = empty ? tag : tag_mem[rd_ptr];
	assign in_credit   = send; // a freed slot goes back to the producer.

	always_ff @(posedge clk) begin
		if (push) begin
			prod_mem[wr_ptr] <= product;
			tag_mem[wr_ptr]  <= tag;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_cnt   <= '0;
			credit_cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (send) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, send})
				2'b10:   fill_cnt <= fill_cnt + 1'b1;
				2'b01:   fill_cnt <= fill_cnt - 1'b1;
				default: fill_cnt <= fill_cnt;
			endcase
			case ({out_credit, send})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// holds only while the producer keeps to its input credits.
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!arst_n)
		push |-> fill_cnt != mul_count_t'(DEPTH)
	);

	a_credit_no_wrap: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_credit && !send |=> credit_cnt > $past(credit_cnt)
	);

endmodule

`default_nettype wire

// ==== source/carry_prop_adder.sv ====
`timescale 1ns/100ps
`default_nettype none

module carry_prop_adder (
	input  logic                  clk,
	input  logic                  arst_n,
	carry_save_if.sink            cs,
	output logic                  push,
	output mul_pkg::mul_product_t product,
	output mul_pkg::mul_tag_t     tag
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			push <= 1'b0;
		end else begin
			push <= cs.valid;
		end
	end

	// 64 bit sum, carry out of the top column is lost.
	always_ff @(posedge clk) begin
		if (cs.valid) begin
			product <= cs.sum + cs.carry;
			tag     <= cs.tag;
		end
	end

endmodule

`default_nettype wire

// ==== source/wallace_tree.sv ====
`timescale 1ns/100ps
`default_nettype none

module wallace_tree (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               pp_valid,
	input  mul_pkg::mul_rows_t pp_rows,
	input  mul_pkg::mul_tag_t  pp_tag,
	carry_save_if.source       cs
);
	import mul_pkg::*;

	mul_rows_t                    lower_rows; // after level four.
	mul_rows_t                    upper_rows; // after level eight, rows 0 and 1 live.
	mul_product_t [MID_ROWS-1:0]  mid_rows;
	logic                         mid_valid;
	mul_tag_t                     mid_tag;

	// one reduction level on the first n rows.
	// consecutive triples compress into sum/carry pairs packed at the front,
	// the one or two rows that do not fill a triple follow them unchanged.
	function automatic mul_rows_t csa_level(input mul_rows_t rows, input int n);
		mul_rows_t next;
		csa_pair_t pair;
		int        groups;
		groups = n / 3;
		next   = '0;
		for (int g = 0; g < PP_ROWS / 3; g++) begin
			if (g < groups) begin
				pair          = csa_3to2(rows[3*g], rows[3*g+1], rows[3*g+2]);
				next[2*g]     = pair.sum;
				next[2*g+1]   = pair.carry;
			end
		end
		for (int j = 0; j < 2; j++) begin
			if (j < n % 3) begin
				next[2*groups+j] = rows[3*groups+j];
			end
		end
		return next;
	endfunction

	always_comb begin
		lower_rows = pp_rows;
		for (int lvl = 0; lvl < MID_LEVELS; lvl++) begin
			lower_rows = csa_level(lower_rows, LEVEL_ROWS[lvl]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mid_valid <= 1'b0;
		end else begin
			mid_valid <= pp_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pp_valid) begin
			mid_rows <= lower_rows[MID_ROWS-1:0];
			mid_tag  <= pp_tag;
		end
	end

	always_comb begin
		upper_rows               = '0;
		upper_rows[MID_ROWS-1:0] = mid_rows;
		for (int lvl = MID_LEVELS; lvl < TREE_LEVELS; lvl++) begin
			upper_rows = csa_level(upper_rows, LEVEL_ROWS[lvl]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cs.valid <= 1'b0;
		end else begin
			cs.valid <= mid_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (mid_valid) begin
			cs.sum   <= upper_rows[0];
			cs.carry <= upper_rows[1];
			cs.tag   <= mid_tag;
		end
	end

	// a live operation leaves the tree with a known tag.
	a_tag_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		cs.valid |-> !$isunknown(cs.tag)
	);

endmodule

`default_nettype wire

// ==== source/partial_products.sv ====
`timescale 1ns/100ps
`default_nettype none

module partial_products (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  mul_pkg::mul_operand_t a,
	input  mul_pkg::mul_operand_t b,
	input  mul_pkg::mul_tag_t     tag,
	output logic                  pp_valid,
	output mul_pkg::mul_rows_t    pp_rows,
	output mul_pkg::mul_tag_t     pp_tag
);
	import mul_pkg::*;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pp_valid <= 1'b0;
		end else begin
			pp_valid <= in_valid;
		end
	end

	// row i is a shifted by i, gated by b[i].
	always_ff @(posedge clk) begin
		if (in_valid) begin
			for (int i = 0; i < PP_ROWS; i++) begin
				if (b[i]) begin
					pp_rows[i] <= mul_product_t'(a) << i;
				end else begin
					pp_rows[i] <= '0;
				end
			end
			pp_tag <= tag;
		end
	end

endmodule

`default_nettype wire

// ==== source/carry_save_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface carry_save_if;
	import mul_pkg::*;

	logic         valid;
	mul_product_t sum;
	mul_product_t carry;
	mul_tag_t     tag;

	modport source (
		output valid,
		output sum,
		output carry,
		output tag
	);

	modport sink (
		input valid,
		input sum,
		input carry,
		input tag
	);

endinterface

`default_nettype wire

// ==== source/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

	typedef logic [31:0] mul_operand_t;
	typedef logic [63:0] mul_product_t; // full product, also one tree row.
	typedef logic [7:0]  mul_tag_t;

	localparam int RESULT_DEPTH = 8;

	typedef logic [$clog2(RESULT_DEPTH + 1) - 1:0] mul_count_t;

	localparam int PP_ROWS     = 32;
	localparam int TREE_LEVELS = 8;
	localparam int MID_LEVELS  = 4; // levels ahead of the mid-tree register.

	// rows entering each level, last entry is what the final level leaves.
	localparam int LEVEL_ROWS [TREE_LEVELS + 1] = '{32, 22, 15, 10, 7, 5, 4, 3, 2};

	localparam int MID_ROWS = LEVEL_ROWS[MID_LEVELS];

	typedef mul_product_t [PP_ROWS - 1:0] mul_rows_t;

	typedef struct packed {
		mul_product_t sum;
		mul_product_t carry;
	} csa_pair_t;

	// full adder on every bit column, carries move one column up.
	function automatic csa_pair_t csa_3to2(
		input mul_product_t x,
		input mul_product_t y,
		input mul_product_t z
	);
		csa_pair_t pair;
		pair.sum   = x ^ y ^ z;
		pair.carry = ((x & y) | (y & z) | (z & x)) << 1; // bit 63 carry is dropped.
		return pair;
	endfunction

endpackage

`default_nettype wire
